/* filelist.f */
+incdir+hdl
hdl/video_pkg.sv
hdl/mem_pkg.sv
hdl/tile_cen.sv
hdl/tile_timing.sv
hdl/tile_fetch.sv
hdl/tile_rom_arb.sv
hdl/tile_colmix.sv
hdl/tile_game.sv
dv/tile_sdram_model.sv
dv/tile_game_tb.sv

/* Bender.yml */
package:
  name: tile_video

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/video_pkg.sv
      - hdl/mem_pkg.sv
      - hdl/tile_cen.sv
      - hdl/tile_timing.sv
      - hdl/tile_fetch.sv
      - hdl/tile_rom_arb.sv
      - hdl/tile_colmix.sv
      - hdl/tile_game.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tile_sdram_model.sv
      - dv/tile_game_tb.sv

/* dv/tile_game_tb.sv */
// *********************************************************************
// Testbench for the tile video top level. Scans two frames and checks
// table pixels, blanking, line and pixel counts, sync pulses and the
// clock enables.
// The palette is loaded in the first vertical blanking after reset and
// one entry is rewritten between the two frames.
// *********************************************************************
`timescale 1ns/100ps
`include "tile_defines.svh"

module tile_game_tb;

    localparam int TIMEOUT = 20000;
    localparam int COLS    = `TILE_H_ACTIVE / `TILE_SIZE;
    localparam int NPAL    = 2 ** `TILE_PAL_AW;

    // One checked pixel and the palette entry it must show
    typedef struct packed {
        logic [7:0]              x;
        logic [7:0]              y;
        logic [`TILE_PAL_AW-1:0] idx;
    } pix_row_t;

    logic                    clk;
    logic                    rst;
    logic                    pxl2_cen;
    logic                    pxl_cen;
    video_pkg::chan_t        red;
    video_pkg::chan_t        green;
    video_pkg::chan_t        blue;
    logic                    HS;
    logic                    VS;
    logic                    LHBL_dly;
    logic                    LVBL_dly;
    logic                    pal_we;
    logic [`TILE_PAL_AW-1:0] pal_addr;
    video_pkg::colour_t      pal_din;
    mem_pkg::rom_addr_t      ba_addr;
    logic                    ba_rd;
    logic                    ba_ack;
    logic                    ba_rdy;
    mem_pkg::rom_word_t      data_read;

    video_pkg::colour_t exp_pal [NPAL];
    pix_row_t           rows [$];
    int                 vs_count;
    logic               vs_prev;
    int                 hs_count;
    logic               hs_prev;
    int                 cen_clks;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    tile_game u_tile_game (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl2_cen  ( pxl2_cen  ),
        .pxl_cen   ( pxl_cen   ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .HS        ( HS        ),
        .VS        ( VS        ),
        .LHBL_dly  ( LHBL_dly  ),
        .LVBL_dly  ( LVBL_dly  ),
        .pal_we    ( pal_we    ),
        .pal_addr  ( pal_addr  ),
        .pal_din   ( pal_din   ),
        .ba_addr   ( ba_addr   ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    tile_sdram_model u_sdram (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .ba_rd     ( ba_rd     ),
        .ba_addr   ( ba_addr   ),
        .ba_ack    ( ba_ack    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    // Palette entry for pixel (x, y) from the map and graphics rules
    function automatic logic [`TILE_PAL_AW-1:0] expected_index(input int x, input int y);
        int map_addr;
        int code;
        int pal;
        int gfx_addr;
        int nib;
        map_addr = `TILE_MAP_BASE + (y / `TILE_SIZE) * COLS + x / `TILE_SIZE;
        code     = map_addr % 64;
        pal      = map_addr % 8;
        gfx_addr = `TILE_GFX_BASE + code * `TILE_SIZE + y % `TILE_SIZE;
        nib      = (gfx_addr + x % `TILE_SIZE) % 16;
        return `TILE_PAL_AW'(pal * 16 + nib);
    endfunction

    function automatic video_pkg::colour_t init_colour(input int i);
        return video_pkg::colour_t'(i * 'h0123);
    endfunction

    // One clock and a sample just past the edge
    task automatic step_clk;
        @(posedge clk);
        #10;
        if (VS && !vs_prev) vs_count++;
        if (HS && !hs_prev) hs_count++;
        vs_prev = VS;
        hs_prev = HS;
        // Enables counted in clocks since reset was released
        if (rst) begin
            cen_clks = 0;
        end else begin
            cen_clks++;
            check_value("pxl2_cen", pxl2_cen, cen_clks % 2 == 0);
            check_value("pxl_cen", pxl_cen, cen_clks % 4 == 0);
        end
    endtask

    task automatic stop_with_failure;
        $display("Simulation finished: FAIL");
        $fatal(1, "Testbench stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic wait_rise(input bit vertical);
        int    cycles;
        logic  prev;
        logic  cur;
        string name;
        name   = vertical ? "LVBL_dly" : "LHBL_dly";
        cur    = vertical ? LVBL_dly : LHBL_dly;
        cycles = 0;
        do begin
            prev = cur;
            step_clk();
            cur = vertical ? LVBL_dly : LHBL_dly;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: %s did not rise within %0d cycles", name, TIMEOUT);
                stop_with_failure();
            end
        end while (!(prev === 1'b0 && cur === 1'b1));
    endtask

    // Moves to the sample just after the next pixel edge
    task automatic next_pixel;
        int cycles;
        cycles = 0;
        while (pxl_cen !== 1'b1) begin
            step_clk();
            cycles++;
            if (cycles > 8) begin
                $display("Timeout: pxl_cen stopped toggling");
                stop_with_failure();
            end
        end
        step_clk();
    endtask

    task automatic write_palette(input int i, input video_pkg::colour_t colour);
        pal_we     = 1'b1;
        pal_addr   = `TILE_PAL_AW'(i);
        pal_din    = colour;
        exp_pal[i] = colour;
        step_clk();
        pal_we     = 1'b0;
    endtask

    task automatic add_row(input int x, input int y);
        pix_row_t row;
        row.x   = 8'(x);
        row.y   = 8'(y);
        row.idx = expected_index(x, y);
        rows.push_back(row);
    endtask

    task automatic scan_frame(input int frame);
        int       ptr;
        int       x;
        int       y;
        int       hs_mark;
        pix_row_t row;
        ptr = 0;
        wait_rise(1'b1);
        check_value("VS pulse count", vs_count, frame + 1);
        for (y = 0; y < `TILE_V_ACTIVE; y++) begin
            // Line 0 starts with the LVBL_dly rise
            if (y > 0) begin
                wait_rise(1'b0);
                check_value("LVBL_dly", LVBL_dly, 1);
                check_value("HS pulse count in line", hs_count - hs_mark, 1);
            end
            hs_mark = hs_count;
            for (x = 0; x < `TILE_H_ACTIVE; x++) begin
                check_value("LHBL_dly", LHBL_dly, 1);
                if (ptr < rows.size()) begin
                    row = rows[ptr];
                    if (row.x == x && row.y == y) begin
                        check_value("rgb", {red, green, blue}, exp_pal[row.idx]);
                        ptr++;
                    end
                end
                next_pixel();
            end
            // First pixel of horizontal blanking
            check_value("LHBL_dly", LHBL_dly, 0);
            check_value("rgb in hblank", {red, green, blue}, 0);
        end
        wait_rise(1'b0);
        check_value("LVBL_dly", LVBL_dly, 0);
        check_value("rgb in vblank", {red, green, blue}, 0);
        if (ptr != rows.size()) begin
            $display("Table row %0d was never reached in the frame scan", ptr);
            stop_with_failure();
        end
    endtask

    initial begin
        int                 i;
        int                 entry;
        video_pkg::colour_t new_colour;
        void'($urandom(3));
        rst      = 1'b1;
        pal_we   = 1'b0;
        pal_addr = '0;
        pal_din  = '0;
        vs_count = 0;
        vs_prev  = 1'b0;
        hs_count = 0;
        hs_prev  = 1'b0;
        cen_clks = 0;

        // Rows in scan order
        add_row(0, 0);
        add_row(7, 0);
        add_row(8, 0);
        add_row(63, 0);
        add_row(15, 3);
        add_row(16, 7);
        add_row(31, 8);
        add_row(32, 9);
        add_row(0, 15);
        add_row(40, 16);
        add_row(47, 20);
        add_row(48, 23);
        add_row(63, 24);
        add_row(7, 31);
        add_row(56, 31);
        add_row(63, 31);

        repeat (4) step_clk();
        rst = 1'b0;
        check_value("HS", HS, 0);
        check_value("VS", VS, 0);
        check_value("ba_rd", ba_rd, 0);
        check_value("rgb", {red, green, blue}, 0);
        check_value("LHBL_dly", LHBL_dly, 0);
        check_value("LVBL_dly", LVBL_dly, 0);

        // Loaded well before the first active line
        for (i = 0; i < NPAL; i++) begin
            write_palette(i, init_colour(i));
        end
        scan_frame(0);

        // Still in vertical blanking here
        entry      = rows[0].idx;
        new_colour = exp_pal[entry] ^ 15'h7fff;
        write_palette(entry, new_colour);
        scan_frame(1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* dv/tile_sdram_model.sv */
// *********************************************************************
// Read-only SDRAM bank model. One request at a time, random latency.
// Map region words carry code = addr mod 64 and palette = addr mod 8.
// Graphics words hold nibble (addr + k) for pixel k, pixel 0 on top.
// *********************************************************************
`timescale 1ns/100ps
`include "tile_defines.svh"

module tile_sdram_model (
    input  logic               clk,
    input  logic               rst,
    input  logic               ba_rd,
    input  mem_pkg::rom_addr_t ba_addr,
    output logic               ba_ack,
    output logic               ba_rdy,
    output mem_pkg::rom_word_t data_read
);

    typedef enum logic [1:0] {IDLE, ACK, DATA} model_state_t;

    model_state_t       state;
    int unsigned        wait_cnt;
    mem_pkg::rom_addr_t addr_q;

    function automatic mem_pkg::rom_word_t bank_word(input mem_pkg::rom_addr_t addr);
        mem_pkg::rom_word_t word;
        mem_pkg::rom_addr_t sum;
        int                 k;
        word = '0;
        if (addr < `TILE_GFX_BASE) begin
            word[9:0]   = 10'(addr % 64);
            word[12:10] = 3'(addr % 8);
        end else begin
            for (k = 0; k < 8; k++) begin
                sum = addr + mem_pkg::rom_addr_t'(k);
                word[31 - 4*k -: 4] = sum[3:0];
            end
        end
        return word;
    endfunction

    initial begin
        ba_ack    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        state     = IDLE;
        wait_cnt  = 0;
    end

    always @(posedge clk) begin
        ba_ack <= 1'b0;
        ba_rdy <= 1'b0;
        if (rst) begin
            state     <= IDLE;
            wait_cnt  <= 0;
            data_read <= '0;
        end else begin
            case (state)
                IDLE: if (ba_rd) begin
                    wait_cnt <= $urandom % 2;
                    state    <= ACK;
                end
                ACK: if (wait_cnt == 0) begin
                    ba_ack   <= 1'b1;
                    addr_q   <= ba_addr;
                    wait_cnt <= 1 + $urandom % 3;
                    state    <= DATA;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
                DATA: if (wait_cnt == 0) begin
                    ba_rdy    <= 1'b1;
                    data_read <= bank_word(addr_q);
                    state     <= IDLE;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* hdl/tile_game.sv */
// *********************************************************************
// Tile video top level. One read-only SDRAM bank feeds the layer.
// The palette is loaded through the CPU write port.
// *********************************************************************
`timescale 1ns/100ps
`include "tile_defines.svh"

module tile_game (
    input  logic                    clk,
    input  logic                    rst,
    output logic                    pxl2_cen,
    output logic                    pxl_cen,
    output video_pkg::chan_t        red,
    output video_pkg::chan_t        green,
    output video_pkg::chan_t        blue,
    output logic                    HS,
    output logic                    VS,
    output logic                    LHBL_dly,
    output logic                    LVBL_dly,
    // CPU palette port
    input  logic                    pal_we,
    input  logic [`TILE_PAL_AW-1:0] pal_addr,
    input  video_pkg::colour_t      pal_din,
    // Read-only bank
    output mem_pkg::rom_addr_t      ba_addr,
    output logic                    ba_rd,
    input  logic                    ba_ack,
    input  logic                    ba_rdy,
    input  mem_pkg::rom_word_t      data_read
);

    video_pkg::vtiming_t vtiming;
    mem_pkg::tile_t      tile;
    mem_pkg::rom_addr_t  map_addr, gfx_addr;
    mem_pkg::map_word_t  map_data;
    mem_pkg::rom_word_t  gfx_data;
    logic                map_cs, map_ok, gfx_cs, gfx_ok;

    tile_cen u_cen (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    tile_timing u_timing (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .vtiming  ( vtiming  ),
        .HS       ( HS       ),
        .VS       ( VS       ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

    tile_fetch u_fetch (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .vtiming  ( vtiming  ),
        .map_cs   ( map_cs   ),
        .map_addr ( map_addr ),
        .map_data ( map_data ),
        .map_ok   ( map_ok   ),
        .gfx_cs   ( gfx_cs   ),
        .gfx_addr ( gfx_addr ),
        .gfx_data ( gfx_data ),
        .gfx_ok   ( gfx_ok   ),
        .tile     ( tile     )
    );

    tile_rom_arb u_arb (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .map_cs    ( map_cs    ),
        .map_addr  ( map_addr  ),
        .map_data  ( map_data  ),
        .map_ok    ( map_ok    ),
        .gfx_cs    ( gfx_cs    ),
        .gfx_addr  ( gfx_addr  ),
        .gfx_data  ( gfx_data  ),
        .gfx_ok    ( gfx_ok    ),
        .ba_addr   ( ba_addr   ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    tile_colmix u_colmix (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl_cen  ( pxl_cen  ),
        .vtiming  ( vtiming  ),
        .tile     ( tile     ),
        .pal_we   ( pal_we   ),
        .pal_addr ( pal_addr ),
        .pal_din  ( pal_din  ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

endmodule

/* hdl/tile_colmix.sv */
// *********************************************************************
// Pixel shifter, palette RAM and RGB register.
// Pixel h of a line leaves on red/green/blue two pixels after its slot.
// Palette writes from the CPU port land on the next clock.
// *********************************************************************
`timescale 1ns/100ps
`include "tile_defines.svh"

module tile_colmix (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  video_pkg::vtiming_t     vtiming,
    input  mem_pkg::tile_t          tile,
    input  logic                    pal_we,
    input  logic [`TILE_PAL_AW-1:0] pal_addr,
    input  video_pkg::colour_t      pal_din,
    output video_pkg::chan_t        red,
    output video_pkg::chan_t        green,
    output video_pkg::chan_t        blue
);

    video_pkg::colour_t pal_ram [2**`TILE_PAL_AW];
    video_pkg::colour_t pal_rd;
    video_pkg::colour_t rgb;
    video_pkg::pal_t    pal_q;
    video_pkg::pxl_t    pxl;
    mem_pkg::rom_word_t shift_q;
    logic               load;
    logic               vld_q;
    logic               show;

    assign load = pxl_cen && vtiming.hdump[2:0] == 3'd7;
    assign pxl  = shift_q[31:28];

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tile.gfx;
            pal_q   <= tile.pal;
        end else if (pxl_cen) begin
            shift_q <= shift_q << 4;
        end
        if (pal_we) pal_ram[pal_addr] <= pal_din;
        if (pxl_cen) pal_rd <= pal_ram[{pal_q, pxl}];
    end

    // Late tiles and blanking both force black
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= 1'b0;
            show  <= 1'b0;
            rgb   <= '0;
        end else if (pxl_cen) begin
            if (load) vld_q <= tile.valid;
            show <= vld_q && vtiming.LHBL && vtiming.LVBL;
            rgb  <= show ? pal_rd : '0;
        end
    end

    assign {red, green, blue} = rgb;

endmodule

/* hdl/tile_rom_arb.sv */
// *********************************************************************
// Shares the read bank between the map and graphics clients.
// One access at a time, map first. Each client keeps its last word.
// *********************************************************************
`timescale 1ns/100ps

module tile_rom_arb (
    input  logic               clk,
    input  logic               rst,
    input  logic               map_cs,
    input  mem_pkg::rom_addr_t map_addr,
    output mem_pkg::map_word_t map_data,
    output logic               map_ok,
    input  logic               gfx_cs,
    input  mem_pkg::rom_addr_t gfx_addr,
    output mem_pkg::rom_word_t gfx_data,
    output logic               gfx_ok,
    output mem_pkg::rom_addr_t ba_addr,
    output logic               ba_rd,
    input  logic               ba_ack,
    input  logic               ba_rdy,
    input  mem_pkg::rom_word_t data_read
);

    typedef enum logic [1:0] {IDLE, WAIT_ACK, WAIT_RDY} arb_state_t;

    arb_state_t         state;
    logic               owner_gfx;
    logic               map_vld, gfx_vld;
    logic               map_req, gfx_req, done;
    mem_pkg::rom_addr_t map_lat_addr, gfx_lat_addr;

    // ok drops as soon as the client moves to a new address
    assign map_ok  = map_cs && map_vld && map_lat_addr == map_addr;
    assign gfx_ok  = gfx_cs && gfx_vld && gfx_lat_addr == gfx_addr;
    assign map_req = map_cs && !map_ok;
    assign gfx_req = gfx_cs && !gfx_ok;
    assign done    = state == WAIT_RDY && ba_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            ba_rd     <= 1'b0;
            owner_gfx <= 1'b0;
            map_vld   <= 1'b0;
            gfx_vld   <= 1'b0;
        end else begin
            case (state)
                IDLE: if (map_req || gfx_req) begin
                    owner_gfx <= !map_req;
                    ba_rd     <= 1'b1;
                    state     <= WAIT_ACK;
                end
                WAIT_ACK: if (ba_ack) begin
                    ba_rd <= 1'b0;
                    state <= WAIT_RDY;
                end
                WAIT_RDY: if (ba_rdy) begin
                    state <= IDLE;
                    if (owner_gfx) gfx_vld <= 1'b1;
                    else           map_vld <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            ba_addr <= map_req ? map_addr : gfx_addr;
        end
        if (done && owner_gfx) begin
            gfx_data     <= data_read;
            gfx_lat_addr <= ba_addr;
        end
        if (done && !owner_gfx) begin
            map_data     <= mem_pkg::map_word_t'(data_read[15:0]);
            map_lat_addr <= ba_addr;
        end
    end

    a_rd_held: assert property (@(posedge clk) disable iff (rst)
        ba_rd && !ba_ack |=> ba_rd && $stable(ba_addr));

endmodule

/* hdl/tile_fetch.sv */
// *********************************************************************
// Fetches the tile that follows the one on screen. A fetch runs inside
// one 8 pixel slot and is dropped at the boundary if still incomplete.
// The layer is 8 tiles wide.
// *********************************************************************
`timescale 1ns/100ps
`include "tile_defines.svh"

module tile_fetch (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  video_pkg::vtiming_t  vtiming,
    output logic                 map_cs,
    output mem_pkg::rom_addr_t   map_addr,
    input  mem_pkg::map_word_t   map_data,
    input  logic                 map_ok,
    output logic                 gfx_cs,
    output mem_pkg::rom_addr_t   gfx_addr,
    input  mem_pkg::rom_word_t   gfx_data,
    input  logic                 gfx_ok,
    output mem_pkg::tile_t       tile
);

    typedef enum logic [1:0] {IDLE, MAP, GFX, READY} fetch_state_t;

    localparam int COLS = `TILE_H_ACTIVE / `TILE_SIZE;

    fetch_state_t       state;
    logic               boundary;
    logic               start;
    logic               last_col;
    logic [5:0]         col_nxt;
    logic [2:0]         tgt_col;
    logic [2:0]         tile_line;
    video_pkg::vcnt_t   line_nxt;
    video_pkg::vcnt_t   tgt_line;
    video_pkg::vcnt_t   vrow;
    video_pkg::pal_t    pal_buf;
    mem_pkg::rom_word_t gfx_buf;

    assign boundary = pxl_cen && vtiming.hdump[2:0] == 3'd7;
    assign start    = state == IDLE && vtiming.hdump[2:0] == 3'd0;

    // Past the last column the next line's column 0 is fetched
    assign col_nxt  = vtiming.hdump[8:3] + 6'd1;
    assign last_col = col_nxt >= COLS;
    assign tgt_col  = last_col ? 3'd0 : col_nxt[2:0];
    assign tgt_line = last_col ? line_nxt : vtiming.vdump;
    assign vrow     = tgt_line - video_pkg::vcnt_t'(`TILE_V_START);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            map_cs   <= 1'b0;
            gfx_cs   <= 1'b0;
            line_nxt <= 9'd1;
        end else begin
            if (vtiming.hstart) begin
                line_nxt <= (vtiming.vdump == `TILE_V_TOTAL - 1) ? '0 : vtiming.vdump + 9'd1;
            end
            if (boundary) begin
                state  <= IDLE;
                map_cs <= 1'b0;
                gfx_cs <= 1'b0;
            end else begin
                case (state)
                    IDLE: if (start) begin
                        state  <= MAP;
                        map_cs <= 1'b1;
                    end
                    MAP: if (map_ok) begin
                        state  <= GFX;
                        map_cs <= 1'b0;
                        gfx_cs <= 1'b1;
                    end
                    GFX: if (gfx_ok) begin
                        state  <= READY;
                        gfx_cs <= 1'b0;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            map_addr  <= `TILE_MAP_BASE + mem_pkg::rom_addr_t'({vrow[8:3], tgt_col});
            tile_line <= tgt_line[2:0];
        end
        if (state == MAP && map_ok) begin
            gfx_addr <= `TILE_GFX_BASE + mem_pkg::rom_addr_t'({map_data.code, tile_line});
            pal_buf  <= map_data.pal;
        end
        if (state == GFX && gfx_ok) begin
            gfx_buf <= gfx_data;
        end
    end

    assign tile = '{gfx: gfx_buf, pal: pal_buf, valid: state == READY};

    a_fetch_in_time: assert property (@(posedge clk) disable iff (rst)
        boundary && vtiming.LVBL |-> state == READY);

endmodule

/* hdl/tile_timing.sv */
// *********************************************************************
// Raster counters. Blanking and syncs are registered with the counters.
// The delayed blanking matches the two pixel colour pipeline.
// *********************************************************************
`timescale 1ns/100ps
`include "tile_defines.svh"

module tile_timing (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    output video_pkg::vtiming_t  vtiming,
    output logic                 HS,
    output logic                 VS,
    output logic                 LHBL_dly,
    output logic                 LVBL_dly
);

    video_pkg::hcnt_t hnext;
    video_pkg::vcnt_t vnext;
    logic [1:0]       lhbl_dl;
    logic [1:0]       lvbl_dl;

    assign hnext = (vtiming.hdump == `TILE_H_TOTAL - 1) ? '0 : vtiming.hdump + 9'd1;

    always_comb begin
        vnext = vtiming.vdump;
        if (vtiming.hdump == `TILE_H_TOTAL - 1) begin
            vnext = (vtiming.vdump == `TILE_V_TOTAL - 1) ? '0 : vtiming.vdump + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vtiming  <= '0;
            HS       <= 1'b0;
            VS       <= 1'b0;
            lhbl_dl  <= 2'b00;
            lvbl_dl  <= 2'b00;
        end else if (pxl_cen) begin
            vtiming.hdump  <= hnext;
            vtiming.vdump  <= vnext;
            vtiming.LHBL   <= hnext < `TILE_H_ACTIVE;
            vtiming.LVBL   <= vnext >= `TILE_V_START;
            vtiming.hstart <= hnext == 9'd0;
            HS <= hnext >= `TILE_HS_START && hnext < `TILE_HS_END;
            VS <= vnext >= `TILE_VS_START && vnext < `TILE_VS_END;
            // Two pixel delay line
            lhbl_dl <= {lhbl_dl[0], vtiming.LHBL};
            lvbl_dl <= {lvbl_dl[0], vtiming.LVBL};
        end
    end

    assign LHBL_dly = lhbl_dl[1];
    assign LVBL_dly = lvbl_dl[1];

    a_hdump_range: assert property (@(posedge clk) disable iff (rst)
        vtiming.hdump < `TILE_H_TOTAL);

endmodule

/* hdl/tile_cen.sv */
// *********************************************************************
// Clock enables from clk. pxl2_cen every 2nd cycle, pxl_cen every 4th.
// *********************************************************************
`timescale 1ns/100ps

module tile_cen (
    input  logic clk,
    input  logic rst,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= 2'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 2'd1;
            pxl2_cen <= cnt[0];
            pxl_cen  <= &cnt;
        end
    end

endmodule

/* hdl/mem_pkg.sv */
// *********************************************************************
// ROM side types. Bank words are 32 bits, map words use the low 16.
// *********************************************************************
package mem_pkg;

    typedef logic [21:0] rom_addr_t;
    typedef logic [31:0] rom_word_t;
    typedef logic [9:0]  code_t;

    typedef struct packed {
        logic [2:0]      spare;
        video_pkg::pal_t pal;
        code_t           code;
    } map_word_t;

    // Leftmost pixel in gfx[31:28]
    typedef struct packed {
        rom_word_t       gfx;
        video_pkg::pal_t pal;
        logic            valid;
    } tile_t;

endpackage

/* hdl/video_pkg.sv */
// *********************************************************************
// Video types shared by the timing, fetch and colour stages.
// Colour words are 5:5:5 with red in the top field.
// *********************************************************************
package video_pkg;

    typedef logic [8:0] hcnt_t;
    typedef logic [8:0] vcnt_t;

    // Pixel index inside a tile and palette number from the map
    typedef logic [3:0] pxl_t;
    typedef logic [2:0] pal_t;

    // {red, green, blue}
    typedef logic [14:0] colour_t;
    typedef logic [4:0]  chan_t;

    // All fields change together on pxl_cen
    typedef struct packed {
        hcnt_t hdump;
        vcnt_t vdump;
        logic  LHBL;
        logic  LVBL;
        logic  hstart;
    } vtiming_t;

endpackage

/* hdl/tile_defines.svh */
// *********************************************************************
// Screen geometry, tile size, ROM regions and palette depth.
// Active lines sit at the bottom of the frame so that the frame starts
// in vertical blanking straight out of reset.
// Map addresses must stay below TILE_GFX_BASE.
// *********************************************************************
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// Horizontal, in pixels
`define TILE_H_TOTAL    96
`define TILE_H_ACTIVE   64
`define TILE_HS_START   72
`define TILE_HS_END     80

// Vertical, in lines
`define TILE_V_TOTAL    40
`define TILE_V_ACTIVE   32
`define TILE_V_START    (`TILE_V_TOTAL - `TILE_V_ACTIVE)
`define TILE_VS_START   2
`define TILE_VS_END     4

`define TILE_SIZE       8

// Word addresses in the read-only bank
`define TILE_MAP_BASE   22'h000100
`define TILE_GFX_BASE   22'h010000

`define TILE_PAL_AW     7

`endif
